/* list.f */
hw/core_pkg.sv
hw/mem_bus_if.sv
hw/reg_file.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/exec_stage.sv
hw/mips_core.sv
verif/tb_mips_core.sv

/* verif/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] RESET_PC     = 32'h0;
    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam int          HALT_BUDGET  = 1000;   // cycles allowed per program
    localparam int          DRAIN_CYCLES = 40;
    localparam int          RUNS         = 8;
    localparam int          RUN_STEPS    = RESET_CYCLES + 2 + HALT_BUDGET + DRAIN_CYCLES;
    localparam int          WATCHDOG_CYCLES = RUNS * RUN_STEPS + 20;
    localparam int          MEM_WORDS    = 1024;
    localparam logic [15:0] DATA_BASE    = 16'h0400;
    localparam logic [31:0] LFSR_SEED    = 32'h762e_37a2;

    // MIPS32 encodings
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LB    = 6'h20;   // not supported by the core
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_MULT  = 6'h18;   // not supported either
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    logic        clk;
    logic        resetn;
    logic        mem_valid;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        halted;
    logic        exc_invalid;
    logic [31:0] exc_pc;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog[$];
    logic [31:0] st_addr[$];
    logic [31:0] st_data[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    int          pad_count;
    int          errors;
    int          tests;
    logic        random_ready;
    logic [31:0] lfsr;

    mips_core #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .resetn(resetn),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_we(mem_we), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .halted(halted), .exc_invalid(exc_invalid), .exc_pc(exc_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // combinational read, data valid in the handshake cycle
    assign mem_rdata = (mem_valid === 1'b1) ? mem[mem_addr[11:2]] : 32'd0;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            lfsr      = lfsr_next(lfsr);   // one step per bit
            mem_ready = lfsr[0];
        end else begin
            mem_ready = 1'b1;
        end
    end

    // handshakes are stable by the falling edge
    always @(negedge clk) begin
        if (resetn && mem_valid === 1'b1 && mem_ready) begin
            if (mem_addr[31:12] != 20'd0 || mem_addr[1:0] != 2'd0) begin
                errors++;
                $display("error: memory access to unmapped or unaligned address %h", mem_addr);
            end else if (mem_we) begin
                mem[mem_addr[11:2]] = mem_wdata;
                st_addr.push_back(mem_addr);
                st_data.push_back(mem_wdata);
            end
        end
    end

    function automatic logic [31:0] sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] zext16(input logic [15:0] imm);
        return {16'h0000, imm};
    endfunction

    function automatic logic [31:0] slt_word(input logic [31:0] a, input logic [31:0] b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] pc_next();
        return RESET_PC + prog.size() * 4;
    endfunction

    // 16-bit word offset from the slot after pc to target
    function automatic logic [15:0] branch_off(input logic [31:0] pc, input logic [31:0] target);
        int off;
        off = (int'(target) - int'(pc) - 4) / 4;
        return off[15:0];
    endfunction

    task automatic new_program(input int pads);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        pad_count = pads;
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
        repeat (pad_count) prog.push_back(r_word(FN_ADDU, 5'd0, 5'd0, 5'd0));
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_reg(input logic [4:0] rt, input int slot, input logic [31:0] value);
        emit(i_word(OP_SW, rt, 5'd0, DATA_BASE + slot * 4));
        expect_store({16'h0000, DATA_BASE} + slot * 4, value);
    endtask

    task automatic self_jump();
        prog.push_back(j_word(OP_J, pc_next()));
    endtask

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hfc00_0000 | (i << 2);   // opcode 3f, never valid
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[RESET_PC[11:2] + i] = prog[i];
        end
    endtask

    task automatic reset_core(input string name);
        @(posedge clk);
        #1 resetn = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            if (i > 0 && mem_valid !== 1'b0) begin
                errors++;
                $display("error: %s mem_valid in reset expected 0 actual %b", name, mem_valid);
            end
            @(posedge clk);
        end
        #1 resetn = 1'b1;
        @(negedge clk);
        if (halted !== 1'b0 || exc_invalid !== 1'b0) begin
            errors++;
            $display("error: %s halted/exc_invalid after reset expected 0/0 actual %b/%b",
                     name, halted, exc_invalid);
        end
        @(negedge clk);
        if (mem_valid !== 1'b1 || mem_addr !== RESET_PC) begin
            errors++;
            $display("error: %s first fetch expected valid at %h actual valid %b at %h",
                     name, RESET_PC, mem_valid, mem_addr);
        end
    endtask

    task automatic compare_stores(input string name);
        int n;
        int k;
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        if (st_addr.size() != exp_addr.size()) begin
            errors++;
            $display("error: %s store count expected %0d actual %0d",
                     name, exp_addr.size(), st_addr.size());
        end
        for (k = 0; k < n; k++) begin
            if (st_addr[k] !== exp_addr[k] || st_data[k] !== exp_data[k]) begin
                errors++;
                $display("error: %s store %0d expected [%h]=%h actual [%h]=%h",
                         name, k, exp_addr[k], exp_data[k], st_addr[k], st_data[k]);
            end
        end
    endtask

    task automatic run_program(input string name, input logic exp_invalid,
                               input logic [31:0] exp_pc);
        int cycles;
        tests++;
        load_memory();
        st_addr.delete();
        st_data.delete();
        reset_core(name);
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_BUDGET) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            errors++;
            $display("error: %s core did not halt within %0d cycles", name, HALT_BUDGET);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);   // pending store, late stray stores
        if (exc_invalid !== exp_invalid) begin
            errors++;
            $display("error: %s exc_invalid expected %b actual %b", name, exp_invalid, exc_invalid);
        end
        if (exp_invalid && exc_pc !== exp_pc) begin
            errors++;
            $display("error: %s exc_pc expected %h actual %h", name, exp_pc, exc_pc);
        end
        compare_stores(name);
    endtask

    // dependent chain, each result stored
    task automatic build_alu_program();
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9, r10, r11, r12;
        r1  = sext16(16'h1234);
        r2  = r1 | zext16(16'h8001);
        r3  = r2 & zext16(16'hf0f0);
        r4  = {16'hdead, 16'h0000};
        r5  = r4 + r2;
        r6  = r3 - r4;
        r7  = r5 & r6;
        r8  = r7 | r1;
        r9  = slt_word(r4, r1);
        r10 = slt_word(r1, sext16(16'hfffb));
        r11 = slt_word(r4, sext16(16'h7fff));
        r12 = r1 + sext16(16'hfff0);
        emit(i_word(OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        emit(i_word(OP_ORI, 5'd2, 5'd1, 16'h8001));
        emit(i_word(OP_ANDI, 5'd3, 5'd2, 16'hf0f0));
        store_reg(5'd3, 0, r3);
        emit(i_word(OP_LUI, 5'd4, 5'd0, 16'hdead));
        emit(r_word(FN_ADDU, 5'd5, 5'd4, 5'd2));
        emit(r_word(FN_SUBU, 5'd6, 5'd3, 5'd4));
        emit(r_word(FN_AND, 5'd7, 5'd5, 5'd6));
        emit(r_word(FN_OR, 5'd8, 5'd7, 5'd1));
        store_reg(5'd8, 1, r8);
        emit(r_word(FN_SLT, 5'd9, 5'd4, 5'd1));
        store_reg(5'd9, 2, r9);
        emit(i_word(OP_SLTI, 5'd10, 5'd1, 16'hfffb));
        emit(i_word(OP_SLTI, 5'd11, 5'd4, 16'h7fff));
        emit(i_word(OP_ADDIU, 5'd12, 5'd1, 16'hfff0));
        store_reg(5'd12, 3, r12);
        store_reg(5'd11, 4, r11);
        store_reg(5'd10, 5, r10);
        store_reg(5'd1, 6, r1);
        store_reg(5'd2, 7, r2);
        store_reg(5'd4, 8, r4);
        store_reg(5'd5, 9, r5);
        store_reg(5'd6, 10, r6);
        store_reg(5'd7, 11, r7);
        self_jump();
    endtask

    task automatic alu_results();
        new_program(2);   // no operand comes from execute
        build_alu_program();
        run_program("alu_results", 1'b0, 32'd0);
    endtask

    task automatic back_to_back();
        new_program(0);
        build_alu_program();
        run_program("back_to_back", 1'b0, 32'd0);
    endtask

    task automatic load_store();
        logic [31:0] r1, r3, r6;
        new_program(0);
        r1 = sext16(16'h5a5a);
        r3 = r1 + sext16(16'h0007);
        r6 = r3 + r3;
        emit(i_word(OP_ADDIU, 5'd1, 5'd0, 16'h5a5a));
        store_reg(5'd1, 0, r1);
        emit(i_word(OP_LW, 5'd2, 5'd0, DATA_BASE));
        emit(i_word(OP_ADDIU, 5'd3, 5'd2, 16'h0007));   // load-use
        store_reg(5'd3, 1, r3);
        emit(i_word(OP_ADDIU, 5'd4, 5'd0, DATA_BASE + 16'd8));
        emit(i_word(OP_LW, 5'd5, 5'd4, 16'hfffc));      // negative offset
        emit(r_word(FN_ADDU, 5'd6, 5'd5, 5'd5));
        store_reg(5'd6, 2, r6);
        emit(i_word(OP_ADDIU, 5'd0, 5'd0, 16'h0077));
        emit(r_word(FN_ADDU, 5'd7, 5'd0, 5'd0));
        store_reg(5'd0, 3, 32'd0);
        store_reg(5'd7, 4, 32'd0);
        emit(i_word(OP_LW, 5'd0, 5'd0, DATA_BASE + 16'd4));
        store_reg(5'd0, 5, 32'd0);
        self_jump();
        run_program("load_store", 1'b0, 32'd0);
    endtask

    task automatic branch_jump();
        logic [31:0] loop_pc;
        logic [31:0] jal_pc;
        new_program(0);
        emit(i_word(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        emit(i_word(OP_ADDIU, 5'd2, 5'd0, 16'd6));
        emit(i_word(OP_BEQ, 5'd2, 5'd1, 16'd1));   // not taken
        store_reg(5'd1, 0, sext16(16'd5));
        emit(i_word(OP_BEQ, 5'd1, 5'd1, 16'd1));
        emit(i_word(OP_SW, 5'd2, 5'd0, DATA_BASE + 16'd4));   // skipped
        emit(i_word(OP_BNE, 5'd2, 5'd1, 16'd1));
        emit(i_word(OP_SW, 5'd2, 5'd0, DATA_BASE + 16'd8));   // skipped
        emit(i_word(OP_BNE, 5'd1, 5'd1, 16'd1));   // not taken
        store_reg(5'd2, 3, sext16(16'd6));
        emit(i_word(OP_ADDIU, 5'd4, 5'd0, 16'd3));
        emit(i_word(OP_ADDIU, 5'd5, 5'd0, 16'd0));
        loop_pc = pc_next();
        emit(i_word(OP_ADDIU, 5'd5, 5'd5, 16'd2));
        emit(i_word(OP_ADDIU, 5'd4, 5'd4, 16'hffff));
        emit(i_word(OP_BNE, 5'd0, 5'd4, branch_off(pc_next(), loop_pc)));
        store_reg(5'd4, 4, 32'd0);
        store_reg(5'd5, 5, 32'd3 * 32'd2);   // three passes of +2
        emit(j_word(OP_J, pc_next() + 8));
        emit(i_word(OP_SW, 5'd2, 5'd0, DATA_BASE + 16'h10));   // skipped
        jal_pc = pc_next();
        emit(j_word(OP_JAL, jal_pc + 16));
        emit(i_word(OP_SW, 5'd1, 5'd0, DATA_BASE + 16'h14));   // after return
        emit(i_word(OP_SW, 5'd31, 5'd0, DATA_BASE + 16'h18));
        self_jump();
        emit(i_word(OP_ADDIU, 5'd3, 5'd0, 16'd9));   // subroutine
        emit(i_word(OP_SW, 5'd3, 5'd0, DATA_BASE + 16'h1c));
        emit(r_word(FN_JR, 5'd0, 5'd31, 5'd0));
        expect_store(32'h41c, sext16(16'd9));
        expect_store(32'h414, sext16(16'd5));
        expect_store(32'h418, jal_pc + 4);
        run_program("branch_jump", 1'b0, 32'd0);
    endtask

    task automatic invalid_and_self_jump();
        logic [31:0] bad_pc;
        new_program(0);
        emit(i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0011));
        store_reg(5'd1, 0, sext16(16'h0011));
        bad_pc = pc_next();
        emit(i_word(OP_LB, 5'd2, 5'd0, 16'h0000));
        emit(i_word(OP_SW, 5'd1, 5'd0, DATA_BASE + 16'd4));   // must not happen
        self_jump();
        run_program("invalid_opcode", 1'b1, bad_pc);

        new_program(0);
        emit(i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0012));
        store_reg(5'd1, 0, sext16(16'h0012));
        bad_pc = pc_next();
        emit(r_word(FN_MULT, 5'd0, 5'd1, 5'd1));
        emit(i_word(OP_SW, 5'd1, 5'd0, DATA_BASE + 16'd4));
        self_jump();
        run_program("invalid_funct", 1'b1, bad_pc);

        new_program(0);
        emit(i_word(OP_ADDIU, 5'd1, 5'd0, 16'h0022));
        store_reg(5'd1, 0, sext16(16'h0022));
        self_jump();
        emit(i_word(OP_SW, 5'd1, 5'd0, DATA_BASE + 16'd4));
        run_program("self_jump", 1'b0, 32'd0);
    endtask

    task automatic random_backpressure();
        lfsr         = LFSR_SEED;
        random_ready = 1'b1;
        new_program(2);
        build_alu_program();
        run_program("random_backpressure", 1'b0, 32'd0);
        random_ready = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("error: watchdog expired after %0d cycles, core stuck", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        resetn       = 1'b0;
        mem_ready    = 1'b1;
        random_ready = 1'b0;
        lfsr         = LFSR_SEED;
        errors       = 0;
        tests        = 0;
        pad_count    = 0;
        alu_results();
        back_to_back();
        load_store();
        branch_jump();
        invalid_and_self_jump();
        random_backpressure();
        $display("programs run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        resetn,
    output logic        mem_valid,
    input  logic        mem_ready,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,
    output logic        halted,
    output logic        exc_invalid,
    output logic [31:0] exc_pc
);
    import core_pkg::*;

    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        f_valid;
    instr_t      f_instr;
    logic [31:0] f_pc;
    logic        exec_ready;
    dec_out_t    d_out;
    logic [4:0]  regidx1;
    logic [4:0]  regidx2;
    logic [31:0] regval1;
    logic [31:0] regval2;
    logic [4:0]  e_dst;
    logic [31:0] e_val;
    logic        wr_en;
    logic [4:0]  wr_idx;
    logic [31:0] wr_data;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .resetn(resetn), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .halt(halted), .bus(fetch_bus),
        .f_valid(f_valid), .f_instr(f_instr), .f_pc(f_pc)
    );

    decode_stage u_decode (
        .clk(clk), .resetn(resetn), .f_valid(f_valid), .f_instr(f_instr), .f_pc(f_pc),
        .exec_ready(exec_ready), .regval1(regval1), .regval2(regval2),
        .e_dst(e_dst), .e_val(e_val), .stall(stall), .regidx1(regidx1), .regidx2(regidx2),
        .d_out(d_out), .redirect(redirect), .redirect_pc(redirect_pc), .halt(halted),
        .exc_invalid(exc_invalid), .exc_pc(exc_pc)
    );

    exec_stage u_exec (
        .clk(clk), .resetn(resetn), .d_out(d_out), .exec_ready(exec_ready),
        .e_dst(e_dst), .e_val(e_val), .wr_en(wr_en), .wr_idx(wr_idx),
        .wr_data(wr_data), .bus(data_bus)
    );

    reg_file u_regs (
        .clk(clk), .resetn(resetn), .regidx1(regidx1), .regidx2(regidx2),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .regval1(regval1), .regval2(regval2)
    );

    mem_arbiter u_arb (
        .clk(clk), .resetn(resetn), .fetch_bus(fetch_bus), .data_bus(data_bus),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_we(mem_we), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic               clk,
    input  logic               resetn,
    input  core_pkg::dec_out_t d_out,
    output logic               exec_ready,
    output logic [4:0]         e_dst,
    output logic [31:0]        e_val,
    output logic               wr_en,
    output logic [4:0]         wr_idx,
    output logic [31:0]        wr_data,
    mem_bus_if.requester       bus
);
    import core_pkg::*;

    dec_out_t    x;          // instruction being executed
    logic        mem_op;
    logic        done;
    logic [31:0] alu_out;
    logic [31:0] result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            x.valid <= 1'b0;
        end else if (exec_ready) begin
            x <= d_out;
        end
    end

    always_comb begin
        case (x.alu_op)
            ALU_ADD: alu_out = x.val1 + x.val2;
            ALU_SUB: alu_out = x.val1 - x.val2;
            ALU_AND: alu_out = x.val1 & x.val2;
            ALU_OR:  alu_out = x.val1 | x.val2;
            ALU_SLT: alu_out = {31'd0, $signed(x.val1) < $signed(x.val2)};
            default: alu_out = x.val2;
        endcase
    end

    assign mem_op     = x.is_load || x.is_store;
    assign done       = x.valid && (!mem_op || bus.ready);
    assign exec_ready = !x.valid || done;

    // held stable by x until the handshake
    assign bus.valid = x.valid && mem_op;
    assign bus.addr  = alu_out;
    assign bus.we    = x.is_store;
    assign bus.wdata = x.sdata;

    assign result  = x.is_load ? bus.rdata : alu_out;
    assign wr_en   = done && (x.dst != 5'd0);
    assign wr_idx  = x.dst;
    assign wr_data = result;
    assign e_dst   = wr_en ? x.dst : 5'd0;   // no forward while a load waits
    assign e_val   = result;

    // decode never gives a store a destination
    assert property (@(posedge clk) disable iff (!resetn) (x.valid && x.is_store) |-> !wr_en)
        else $error("store instruction wrote the register file");

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               f_valid,
    input  core_pkg::instr_t   f_instr,
    input  logic [31:0]        f_pc,
    input  logic               exec_ready,
    input  logic [31:0]        regval1,
    input  logic [31:0]        regval2,
    input  logic [4:0]         e_dst,
    input  logic [31:0]        e_val,
    output logic               stall,
    output logic [4:0]         regidx1,
    output logic [4:0]         regidx2,
    output core_pkg::dec_out_t d_out,
    output logic               redirect,
    output logic [31:0]        redirect_pc,
    output logic               halt,
    output logic               exc_invalid,
    output logic [31:0]        exc_pc
);
    import core_pkg::*;

    logic        d_valid;
    instr_t      d_instr;
    logic [31:0] d_pc;
    logic [5:0]  code_q;     // sticky exception code
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] pc4;
    logic [31:0] imm_se;
    logic [31:0] imm_ze;
    logic [31:0] imm_hi;
    logic [31:0] br_target;
    logic [31:0] j_target;
    logic [31:0] target;
    logic [5:0]  code_now;
    logic        invalid;
    logic        jump;
    logic        self_jump;
    logic        issue;
    logic        fire;

    function automatic logic [31:0] fwd(input logic [4:0] idx, input logic [31:0] rf_val,
                                        input logic [4:0] ex_dst, input logic [31:0] ex_val);
        if (idx == 5'd0)
            return 32'd0;
        if (idx == ex_dst)
            return ex_val;   // completing in execute this cycle
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= f_valid && !redirect;   // drop the sequential word
            d_instr <= f_instr;
            d_pc    <= f_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            code_q <= 6'd0;
        end else if (fire) begin
            code_q <= code_now;
        end
    end

    assign regidx1 = d_instr.i.rs;
    assign regidx2 = d_instr.i.rt;
    assign v1      = fwd(d_instr.i.rs, regval1, e_dst, e_val);
    assign v2      = fwd(d_instr.i.rt, regval2, e_dst, e_val);

    assign pc4       = d_pc + 32'd4;
    assign imm_se    = {{16{d_instr.i.imm16[15]}}, d_instr.i.imm16};
    assign imm_ze    = {16'h0000, d_instr.i.imm16};
    assign imm_hi    = {d_instr.i.imm16, 16'h0000};
    assign br_target = pc4 + {imm_se[29:0], 2'b00};
    assign j_target  = {d_pc[31:28], d_instr.i[25:0], 2'b00};

    assign issue = d_valid && exec_ready && !code_q[5];

    always_comb begin
        invalid        = 1'b0;
        jump           = 1'b0;
        target         = br_target;
        d_out.alu_op   = ALU_ADD;
        d_out.val1     = v1;
        d_out.val2     = v2;
        d_out.sdata    = v2;
        d_out.dst      = 5'd0;
        d_out.is_load  = 1'b0;
        d_out.is_store = 1'b0;
        case (d_instr.r.op)
            SPE: begin
                d_out.dst = d_instr.r.rd;
                case (d_instr.r.funct)
                    ADDU: d_out.alu_op = ALU_ADD;
                    SUBU: d_out.alu_op = ALU_SUB;
                    AND:  d_out.alu_op = ALU_AND;
                    OR:   d_out.alu_op = ALU_OR;
                    SLT:  d_out.alu_op = ALU_SLT;
                    JR: begin
                        d_out.dst = 5'd0;
                        jump      = 1'b1;
                        target    = v1;
                    end
                    default: invalid = 1'b1;
                endcase
            end
            ADDIU: begin
                d_out.dst  = d_instr.i.rt;
                d_out.val2 = imm_se;
            end
            SLTI: begin
                d_out.alu_op = ALU_SLT;
                d_out.dst    = d_instr.i.rt;
                d_out.val2   = imm_se;
            end
            ANDI: begin
                d_out.alu_op = ALU_AND;
                d_out.dst    = d_instr.i.rt;
                d_out.val2   = imm_ze;
            end
            ORI: begin
                d_out.alu_op = ALU_OR;
                d_out.dst    = d_instr.i.rt;
                d_out.val2   = imm_ze;
            end
            LUI: begin
                d_out.alu_op = ALU_PASS;
                d_out.dst    = d_instr.i.rt;
                d_out.val2   = imm_hi;
            end
            LW: begin
                d_out.dst     = d_instr.i.rt;
                d_out.val2    = imm_se;   // offset
                d_out.is_load = 1'b1;
            end
            SW: begin
                d_out.val2     = imm_se;
                d_out.is_store = 1'b1;
            end
            BEQ: jump = (v1 == v2);
            BNE: jump = (v1 != v2);
            J: begin
                jump   = 1'b1;
                target = j_target;
            end
            JAL: begin
                jump         = 1'b1;
                target       = j_target;
                d_out.alu_op = ALU_PASS;
                d_out.dst    = 5'd31;
                d_out.val2   = pc4;   // link
            end
            default: invalid = 1'b1;
        endcase
        self_jump   = jump && (target == d_pc);
        code_now    = invalid ? EXC_INVALID : (self_jump ? EXC_SELF_JUMP : 6'd0);
        d_out.valid = issue && !code_now[5];
    end

    assign fire        = issue && code_now[5];
    assign redirect    = issue && jump && !self_jump;
    assign redirect_pc = target;
    assign halt        = code_q[5] || fire;
    assign stall       = (d_valid && !exec_ready) || halt;
    assign exc_invalid = code_q[5] ? (code_q == EXC_INVALID) : (fire && code_now == EXC_INVALID);
    assign exc_pc      = d_pc;   // decode register freezes once halted

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             stall,
    input  logic             redirect,
    input  logic [31:0]      redirect_pc,
    input  logic             halt,
    mem_bus_if.requester     bus,
    output logic             f_valid,
    output core_pkg::instr_t f_instr,
    output logic [31:0]      f_pc
);
    import core_pkg::*;

    logic [31:0] pc;
    logic [31:0] req_addr;   // address held while waiting for ready
    logic        req_hold;
    logic        drop;       // in-flight word belongs to the old path
    logic        active;
    logic        buf_valid;
    instr_t      buf_instr;
    logic [31:0] buf_pc;
    logic        flush;
    logic        room;
    logic        hs;

    assign flush = redirect || halt;
    assign room  = !buf_valid || !stall;   // empty, or decode takes it now
    assign hs    = bus.valid && bus.ready;

    assign bus.valid = req_hold || (active && room && !flush);
    assign bus.addr  = req_hold ? req_addr : pc;
    assign bus.we    = 1'b0;
    assign bus.wdata = 32'd0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc        <= RESET_PC;
            req_hold  <= 1'b0;
            drop      <= 1'b0;
            active    <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            active   <= 1'b1;
            req_hold <= bus.valid && !bus.ready;
            if (bus.valid && !bus.ready) begin
                req_addr <= bus.addr;
            end
            if (hs) begin
                drop <= 1'b0;
            end else if (flush && req_hold) begin
                drop <= 1'b1;
            end
            if (redirect) begin
                pc <= redirect_pc;
            end else if (hs && !drop) begin
                pc <= bus.addr + 32'd4;
            end
            if (flush) begin
                buf_valid <= 1'b0;
            end else if (hs && !drop) begin
                buf_valid <= 1'b1;
                buf_instr <= bus.rdata;
                buf_pc    <= bus.addr;
            end else if (!stall) begin
                buf_valid <= 1'b0;
            end
        end
    end

    assign f_valid = buf_valid;
    assign f_instr = buf_instr;
    assign f_pc    = buf_pc;

    // halt must stay up, and nothing may be offered once it is seen
    assert property (@(posedge clk) disable iff (!resetn) halt |=> (halt && !f_valid))
        else $error("halt dropped or fetch offered an instruction after halt");

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic        clk,
    input  logic        resetn,
    mem_bus_if.arbiter  fetch_bus,
    mem_bus_if.arbiter  data_bus,
    output logic        mem_valid,
    input  logic        mem_ready,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata
);
    logic busy;       // request forwarded, no handshake yet
    logic gnt_data;
    logic sel_data;

    // data wins when the port is free, otherwise keep the old grant
    assign sel_data = busy ? gnt_data : data_bus.valid;

    assign mem_valid = sel_data ? data_bus.valid : fetch_bus.valid;
    assign mem_addr  = sel_data ? data_bus.addr  : fetch_bus.addr;
    assign mem_we    = sel_data ? data_bus.we    : fetch_bus.we;
    assign mem_wdata = sel_data ? data_bus.wdata : fetch_bus.wdata;

    assign data_bus.ready  = sel_data && mem_ready;
    assign fetch_bus.ready = !sel_data && mem_ready;
    assign data_bus.rdata  = sel_data ? mem_rdata : 32'd0;
    assign fetch_bus.rdata = sel_data ? 32'd0 : mem_rdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            gnt_data <= 1'b0;
        end else begin
            busy     <= mem_valid && !mem_ready;
            gnt_data <= sel_data;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
                     (mem_valid && !mem_ready) |=> $stable(mem_addr))
        else $error("memory address changed before ready");

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        resetn,
    input  logic [4:0]  regidx1,
    input  logic [4:0]  regidx2,
    input  logic        wr_en,
    input  logic [4:0]  wr_idx,
    input  logic [31:0] wr_data,
    output logic [31:0] regval1,
    output logic [31:0] regval2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;   // r0 stays zero
        end
    end

    assign regval1 = regs[regidx1];
    assign regval2 = regs[regidx2];

endmodule

`default_nettype wire

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    logic        valid;
    logic        ready;
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [31:0] rdata;   // valid with the handshake

    modport requester (
        output valid, addr, we, wdata,
        input  ready, rdata
    );

    modport arbiter (
        input  valid, addr, we, wdata,
        output ready, rdata
    );
endinterface

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef enum logic [5:0] {
        SPE   = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDIU = 6'h09,
        SLTI  = 6'h0a,
        ANDI  = 6'h0c,
        ORI   = 6'h0d,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcode_e;

    // SPECIAL group function field
    typedef enum logic [5:0] {
        JR   = 6'h08,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_e;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_instr_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_instr_t;

    typedef union packed {
        r_instr_t r;
        i_instr_t i;   // low 26 bits double as the jump index
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS   // lui and link value
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        alu_op_e     alu_op;
        logic [31:0] val1;
        logic [31:0] val2;
        logic [31:0] sdata;
        logic [4:0]  dst;
        logic        is_load;
        logic        is_store;
    } dec_out_t;

    // bit 5 set means the core stops
    localparam logic [5:0] EXC_INVALID   = 6'b101010;
    localparam logic [5:0] EXC_SELF_JUMP = 6'b100000;

endpackage

`default_nettype wire
